// ==== logic/id_pkg.sv ====
// Shared decode types for RV32 subset LUI/ADDI/ADD/SUB/BEQ/BNE/JAL only, no CSR or system opcodes
`default_nettype none

package id_pkg;

  // --------------------
  // Major opcodes
  // --------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // --------------------
  // Instruction views
  // --------------------

  // R-type layout, also used for register operand extraction
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // I-type layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Same 32-bit word seen as R or I format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // --------------------
  // Issue operations
  // --------------------

  // ADDI maps to OP_ADD with the immediate operand selected
  typedef enum logic [2:0] {
    OP_NOP = 3'd0,
    OP_LUI = 3'd1,
    OP_ADD = 3'd2,
    OP_SUB = 3'd3,
    OP_BEQ = 3'd4,
    OP_BNE = 3'd5,
    OP_JAL = 3'd6
  } op_e;

endpackage

`default_nettype wire

// ==== logic/rvc_expander.sv ====
// Expands only C.LI, C.ADDI, C.MV and C.J; cm.mva01s is flagged, not expanded; purely combinational
`default_nettype none

module rvc_expander #(
  parameter bit RVC = 1'b1
) (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        compressed_o,
  output logic        illegal_o,
  output logic        macro_o
);
  import id_pkg::*;

  // Expanded word built through the I or R view
  instr_u      word;
  // CI-format immediate, sign-extended to 12 bits
  logic [11:0] ci_imm;
  // CJ-format jump offset, bit 0 always zero
  logic [11:0] cj_off;

  assign ci_imm = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  // Offset bits are scattered across the CJ word
  assign cj_off = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                   instr_i[2], instr_i[11], instr_i[5:3], 1'b0};

  always_comb begin
    word         = '0;
    instr_o      = instr_i;
    compressed_o = 1'b0;
    illegal_o    = 1'b0;
    macro_o      = 1'b0;

    // Low bits 11 mark a full 32-bit word
    if (RVC && (instr_i[1:0] != 2'b11)) begin
      compressed_o = 1'b1;
      // Unexpanded words keep only their 16 bits
      instr_o      = {16'h0000, instr_i[15:0]};

      // Select on funct3 and quadrant
      case ({instr_i[15:13], instr_i[1:0]})
        5'b010_01: begin
          // C.LI becomes ADDI rd, x0, imm
          word.i.imm    = ci_imm;
          word.i.rs1    = 5'd0;
          word.i.funct3 = 3'b000;
          word.i.rd     = instr_i[11:7];
          word.i.opcode = OPC_OP_IMM;
          instr_o       = word;
        end
        5'b000_01: begin
          // C.ADDI becomes ADDI rd, rd, imm
          word.i.imm    = ci_imm;
          word.i.rs1    = instr_i[11:7];
          word.i.funct3 = 3'b000;
          word.i.rd     = instr_i[11:7];
          word.i.opcode = OPC_OP_IMM;
          instr_o       = word;
        end
        5'b100_10: begin
          // C.MV only, rs2 of zero would be C.JR
          if (!instr_i[12] && (instr_i[6:2] != 5'd0)) begin
            word.r.funct7 = 7'b0000000;
            word.r.rs2    = instr_i[6:2];
            word.r.rs1    = 5'd0;
            word.r.funct3 = 3'b000;
            word.r.rd     = instr_i[11:7];
            word.r.opcode = OPC_OP;
            instr_o       = word;
          end else begin
            illegal_o = 1'b1;
          end
        end
        5'b101_01: begin
          // C.J becomes JAL x0, offset
          instr_o = {cj_off[11], cj_off[10:1], cj_off[11], {8{cj_off[11]}},
                     5'd0, OPC_JAL};
        end
        5'b101_10: begin
          // cm.mva01s left raw for the sequencer
          if ((instr_i[12:10] == 3'b011) && (instr_i[6:5] == 2'b11)) begin
            macro_o = 1'b1;
          end else begin
            illegal_o = 1'b1;
          end
        end
        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/macro_sequencer.sv ====
// Handles only cm.mva01s as two ADDI steps; fetch must hold the macro word until it is consumed
`default_nettype none

module macro_sequencer #(
  parameter bit ZCMP = 1'b1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic [31:0] instr_i,
  input  logic        compressed_i,
  input  logic        illegal_i,
  input  logic        macro_i,
  input  logic        load_i,
  input  logic        issue_ack_i,
  output logic [31:0] instr_o,
  output logic        compressed_o,
  output logic        illegal_o,
  output logic        stall_o
);
  import id_pkg::*;

  typedef enum logic {
    ST_FIRST  = 1'b0,
    ST_SECOND = 1'b1
  } state_e;

  state_e state_q;
  state_e state_d;
  // ADDI word for the current step
  instr_u step;

  // Map s-register index to x register, s0/s1 to x8/x9, s2..s7 to x18..x23
  function automatic logic [4:0] sreg(input logic [2:0] r);
    if (r < 3'd2) begin
      return {2'b01, r};
    end
    return 5'd16 + {2'b00, r};
  endfunction

  // --------------------
  // Step generation
  // --------------------
  always_comb begin
    step          = '0;
    step.i.imm    = 12'h000;
    step.i.funct3 = 3'b000;
    step.i.opcode = OPC_OP_IMM;
    if (state_q == ST_FIRST) begin
      // a0 <- r1s
      step.i.rd  = 5'd10;
      step.i.rs1 = sreg(instr_i[9:7]);
    end else begin
      // a1 <- r2s
      step.i.rd  = 5'd11;
      step.i.rs1 = sreg(instr_i[4:2]);
    end

    instr_o      = instr_i;
    compressed_o = compressed_i;
    illegal_o    = illegal_i;
    stall_o      = 1'b0;

    if (macro_i) begin
      if (ZCMP) begin
        instr_o = step;
        // Second step frees fetch only when issue takes the first
        stall_o = (state_q == ST_FIRST) ? 1'b1 : !issue_ack_i;
      end else begin
        illegal_o = 1'b1;
      end
    end
  end

  // --------------------
  // Step state
  // --------------------
  always_comb begin
    state_d = state_q;
    if (flush_i) begin
      state_d = ST_FIRST;
    end else if (ZCMP && macro_i && load_i) begin
      // Advance once the first step sits in the issue register
      if (state_q == ST_FIRST) begin
        state_d = ST_SECOND;
      end else if (issue_ack_i) begin
        // Second step loaded, macro word consumed
        state_d = ST_FIRST;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_FIRST;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
// Decodes only LUI/ADDI/ADD/SUB/BEQ/BNE/JAL; anything else becomes an illegal OP_NOP entry
`default_nettype none

module instr_decoder (
  input  logic [31:0] instr_i,
  input  logic        compressed_i,
  input  logic        illegal_i,
  output id_pkg::op_e op_o,
  output logic [4:0]  rd_o,
  output logic [4:0]  rs1_o,
  output logic [4:0]  rs2_o,
  output logic [31:0] imm_o,
  output logic        use_imm_o,
  output logic        illegal_o,
  output logic        ctrl_flow_o
);
  import id_pkg::*;

  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  instr_u      word;
  logic [31:0] imm_i_ext;
  logic [31:0] imm_u_ext;
  logic [31:0] imm_b_ext;
  logic [31:0] imm_j_ext;
  // Local decode failure before merging with upstream flag
  logic        bad;

  assign word = instr_i;

  // --------------------
  // Immediates
  // --------------------
  assign imm_i_ext = {{20{word.i.imm[11]}}, word.i.imm};
  assign imm_u_ext = {instr_i[31:12], 12'h000};
  // B and J offsets are always even
  assign imm_b_ext = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
  assign imm_j_ext = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};

  always_comb begin
    op_o        = OP_NOP;
    rd_o        = 5'd0;
    rs1_o       = 5'd0;
    rs2_o       = 5'd0;
    imm_o       = 32'h0;
    use_imm_o   = 1'b0;
    ctrl_flow_o = 1'b0;
    bad         = 1'b0;

    case (word.r.opcode)
      OPC_LUI: begin
        op_o      = OP_LUI;
        rd_o      = word.r.rd;
        imm_o     = imm_u_ext;
        use_imm_o = 1'b1;
      end
      OPC_OP_IMM: begin
        // ADDI only
        op_o      = OP_ADD;
        rd_o      = word.r.rd;
        rs1_o     = word.r.rs1;
        imm_o     = imm_i_ext;
        use_imm_o = 1'b1;
        bad       = (word.i.funct3 != 3'b000);
      end
      OPC_OP: begin
        rd_o  = word.r.rd;
        rs1_o = word.r.rs1;
        rs2_o = word.r.rs2;
        if ((word.i.funct3 == 3'b000) && (word.r.funct7 == F7_ADD)) begin
          op_o = OP_ADD;
        end else if ((word.i.funct3 == 3'b000) && (word.r.funct7 == F7_SUB)) begin
          op_o = OP_SUB;
        end else begin
          bad = 1'b1;
        end
      end
      OPC_BRANCH: begin
        // Offset rides in imm, compare uses both registers
        rs1_o       = word.r.rs1;
        rs2_o       = word.r.rs2;
        imm_o       = imm_b_ext;
        ctrl_flow_o = 1'b1;
        if (word.i.funct3 == 3'b000) begin
          op_o = OP_BEQ;
        end else if (word.i.funct3 == 3'b001) begin
          op_o = OP_BNE;
        end else begin
          bad = 1'b1;
        end
      end
      OPC_JAL: begin
        op_o        = OP_JAL;
        rd_o        = word.r.rd;
        imm_o       = imm_j_ext;
        ctrl_flow_o = 1'b1;
      end
      default: begin
        bad = 1'b1;
      end
    endcase

    // Compressed forms only expand to OP-IMM, OP or JAL
    if (compressed_i && (word.r.opcode != OPC_OP_IMM) && (word.r.opcode != OPC_OP) &&
        (word.r.opcode != OPC_JAL)) begin
      bad = 1'b1;
    end

    illegal_o = illegal_i | bad;

    // Illegal entry carries no operation and no register write
    if (illegal_i | bad) begin
      op_o        = OP_NOP;
      rd_o        = 5'd0;
      rs1_o       = 5'd0;
      rs2_o       = 5'd0;
      imm_o       = 32'h0;
      use_imm_o   = 1'b0;
      ctrl_flow_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
// Single-entry decode-to-issue register; flush drops the held entry and blocks fetch that cycle
`default_nettype none

module id_stage #(
  parameter bit RVC  = 1'b1,
  parameter bit ZCMP = 1'b1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  // Fetch side
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_instr_i,
  input  logic [31:0] fetch_pc_i,
  output logic        fetch_ready_o,
  // Issue side
  output logic        issue_valid_o,
  output id_pkg::op_e issue_op_o,
  output logic [4:0]  issue_rd_o,
  output logic [4:0]  issue_rs1_o,
  output logic [4:0]  issue_rs2_o,
  output logic [31:0] issue_imm_o,
  output logic        issue_use_imm_o,
  output logic [31:0] issue_pc_o,
  output logic        issue_illegal_o,
  output logic        issue_compressed_o,
  output logic        issue_ctrl_flow_o,
  output logic [31:0] orig_instr_o,
  input  logic        issue_ack_i
);
  import id_pkg::*;

  // Expander to sequencer
  logic [31:0] exp_instr;
  logic        exp_compressed;
  logic        exp_illegal;
  logic        exp_macro;
  // Sequencer to decoder
  logic [31:0] seq_instr;
  logic        seq_compressed;
  logic        seq_illegal;
  logic        seq_stall;
  // Decoder results
  op_e         dec_op;
  logic [4:0]  dec_rd;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [31:0] dec_imm;
  logic        dec_use_imm;
  logic        dec_illegal;
  logic        dec_ctrl_flow;
  logic [31:0] orig_instr;
  logic        valid_q;
  logic        load;

  rvc_expander #(
    .RVC (RVC)
  ) u_rvc_expander (
    .instr_i      (fetch_instr_i),
    .instr_o      (exp_instr),
    .compressed_o (exp_compressed),
    .illegal_o    (exp_illegal),
    .macro_o      (exp_macro)
  );

  macro_sequencer #(
    .ZCMP (ZCMP)
  ) u_macro_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .instr_i      (exp_instr),
    .compressed_i (exp_compressed),
    .illegal_i    (exp_illegal),
    .macro_i      (exp_macro),
    .load_i       (load),
    .issue_ack_i  (issue_ack_i),
    .instr_o      (seq_instr),
    .compressed_o (seq_compressed),
    .illegal_o    (seq_illegal),
    .stall_o      (seq_stall)
  );

  instr_decoder u_instr_decoder (
    .instr_i      (seq_instr),
    .compressed_i (seq_compressed),
    .illegal_i    (seq_illegal),
    .op_o         (dec_op),
    .rd_o         (dec_rd),
    .rs1_o        (dec_rs1),
    .rs2_o        (dec_rs2),
    .imm_o        (dec_imm),
    .use_imm_o    (dec_use_imm),
    .illegal_o    (dec_illegal),
    .ctrl_flow_o  (dec_ctrl_flow)
  );

  // Compressed words keep only their low half
  assign orig_instr = seq_compressed ? {16'h0000, fetch_instr_i[15:0]} : fetch_instr_i;

  // --------------------
  // Handshakes
  // --------------------

  // Free slot or slot draining this cycle
  assign load          = (!valid_q || issue_ack_i) && fetch_valid_i && !flush_i;
  // First macro step loads without consuming the word
  assign fetch_ready_o = load && !seq_stall;
  assign issue_valid_o = valid_q;

  // --------------------
  // Pipeline register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload follows the valid bit
  always_ff @(posedge clk_i) begin
    if (load) begin
      issue_op_o         <= dec_op;
      issue_rd_o         <= dec_rd;
      issue_rs1_o        <= dec_rs1;
      issue_rs2_o        <= dec_rs2;
      issue_imm_o        <= dec_imm;
      issue_use_imm_o    <= dec_use_imm;
      issue_pc_o         <= fetch_pc_i;
      issue_illegal_o    <= dec_illegal;
      issue_compressed_o <= seq_compressed;
      issue_ctrl_flow_o  <= dec_ctrl_flow;
      orig_instr_o       <= orig_instr;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Clock runs from time zero; reset releases 10 time units after the last reset edge
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== verif/tb_id_stage.sv ====
// Runs with RVC and ZCMP on; inputs change 10 units after each rising edge, issue is single entry
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  // Expected issue entry
  typedef struct packed {
    logic [2:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        use_imm;
    logic        ctrl_flow;
    logic        illegal;
    logic        compressed;
    logic [31:0] pc;
    logic [31:0] orig;
  } entry_t;

  // s0/s1 and s2..s7 as x registers
  localparam logic [4:0] S_MAP [8] = '{5'd8, 5'd9, 5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23};

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        fetch_valid;
  logic [31:0] fetch_instr;
  logic [31:0] fetch_pc;
  logic        fetch_ready;
  logic        issue_valid;
  op_e         issue_op;
  logic [4:0]  issue_rd;
  logic [4:0]  issue_rs1;
  logic [4:0]  issue_rs2;
  logic [31:0] issue_imm;
  logic        issue_use_imm;
  logic [31:0] issue_pc;
  logic        issue_illegal;
  logic        issue_compressed;
  logic        issue_ctrl_flow;
  logic [31:0] orig_instr;
  logic        issue_ack;

  int checks;
  int errors;
  int chk_start;
  int err_start;
  // Fetch handshakes seen
  int consumed = 0;
  // Issue acknowledgements seen while an entry is valid
  int acked = 0;

  tb_clk_gen #(
    .PERIOD     (100),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  id_stage #(
    .RVC  (1'b1),
    .ZCMP (1'b1)
  ) u_id_stage (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .flush_i            (flush),
    .fetch_valid_i      (fetch_valid),
    .fetch_instr_i      (fetch_instr),
    .fetch_pc_i         (fetch_pc),
    .fetch_ready_o      (fetch_ready),
    .issue_valid_o      (issue_valid),
    .issue_op_o         (issue_op),
    .issue_rd_o         (issue_rd),
    .issue_rs1_o        (issue_rs1),
    .issue_rs2_o        (issue_rs2),
    .issue_imm_o        (issue_imm),
    .issue_use_imm_o    (issue_use_imm),
    .issue_pc_o         (issue_pc),
    .issue_illegal_o    (issue_illegal),
    .issue_compressed_o (issue_compressed),
    .issue_ctrl_flow_o  (issue_ctrl_flow),
    .orig_instr_o       (orig_instr),
    .issue_ack_i        (issue_ack)
  );

  // --------------------
  // Handshake counters
  // --------------------

  // Inputs settle 10 units after the edge, so both sides are stable here
  always @(posedge clk) begin
    if (fetch_valid && fetch_ready) begin
      consumed++;
    end
    if (issue_valid && issue_ack) begin
      acked++;
    end
  end

  // --------------------
  // Cycle helpers
  // --------------------

  // Drive point, 10 units past the rising edge
  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  task automatic abort(input string why);
    $display("timeout: %s", why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_field(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic present(input logic [31:0] w, input logic [31:0] pc);
    fetch_valid = 1'b1;
    fetch_instr = w;
    fetch_pc    = pc;
  endtask

  // Bounded wait for ready, sampled 1 unit after the drive point
  task automatic wait_ready();
    int n;
    n = 0;
    #1;
    while (!fetch_ready) begin
      if (n == 20) begin
        abort("fetch_ready_o never rose");
      end
      tick();
      #1;
      n++;
    end
  endtask

  // Word is consumed on the next edge, entry is visible right after
  task automatic take_fetch();
    wait_ready();
    tick();
    fetch_valid = 1'b0;
  endtask

  task automatic ack_entry();
    issue_ack = 1'b1;
    tick();
    issue_ack = 1'b0;
  endtask

  task automatic check_entry(input entry_t e);
    check_field("issue_valid_o", 32'(issue_valid), 32'd1);
    check_field("issue_op_o", 32'(issue_op), 32'(e.op));
    check_field("issue_rd_o", 32'(issue_rd), 32'(e.rd));
    check_field("issue_rs1_o", 32'(issue_rs1), 32'(e.rs1));
    check_field("issue_rs2_o", 32'(issue_rs2), 32'(e.rs2));
    check_field("issue_imm_o", issue_imm, e.imm);
    check_field("issue_use_imm_o", 32'(issue_use_imm), 32'(e.use_imm));
    check_field("issue_ctrl_flow_o", 32'(issue_ctrl_flow), 32'(e.ctrl_flow));
    check_field("issue_illegal_o", 32'(issue_illegal), 32'(e.illegal));
    check_field("issue_compressed_o", 32'(issue_compressed), 32'(e.compressed));
    check_field("issue_pc_o", issue_pc, e.pc);
    check_field("orig_instr_o", orig_instr, e.orig);
  endtask

  // Low bits other than 11 mean a 16-bit word
  task automatic check_illegal(input logic [31:0] w, input logic [31:0] pc);
    logic cmp;
    cmp = (w[1:0] != 2'b11);
    check_field("issue_valid_o", 32'(issue_valid), 32'd1);
    check_field("issue_illegal_o", 32'(issue_illegal), 32'd1);
    check_field("issue_op_o", 32'(issue_op), 32'(OP_NOP));
    check_field("issue_compressed_o", 32'(issue_compressed), 32'(cmp));
    check_field("issue_pc_o", issue_pc, pc);
    check_field("orig_instr_o", orig_instr, cmp ? {16'h0000, w[15:0]} : w);
  endtask

  task automatic begin_test();
    chk_start = checks;
    err_start = errors;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - chk_start, errors - err_start);
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Random 32-bit word of one kind, fields chosen first, then encoded
  task automatic build_rv32(input int kind, output logic [31:0] w, output entry_t e);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] i12;
    logic [19:0] u20;
    logic [12:0] b13;
    logic [20:0] j21;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    i12 = 12'($urandom);
    u20 = 20'($urandom);
    b13 = {12'($urandom), 1'b0};
    j21 = {20'($urandom), 1'b0};
    e   = '0;
    case (kind)
      0: begin
        w         = {u20, rd, OPC_LUI};
        e.op      = OP_LUI;
        e.rd      = rd;
        e.imm     = {u20, 12'h000};
        e.use_imm = 1'b1;
      end
      1: begin
        // ADDI
        w         = {i12, rs1, 3'b000, rd, OPC_OP_IMM};
        e.op      = OP_ADD;
        e.rd      = rd;
        e.rs1     = rs1;
        e.imm     = {{20{i12[11]}}, i12};
        e.use_imm = 1'b1;
      end
      2, 3: begin
        w     = {(kind == 2) ? 7'b0000000 : 7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
        e.op  = (kind == 2) ? OP_ADD : OP_SUB;
        e.rd  = rd;
        e.rs1 = rs1;
        e.rs2 = rs2;
      end
      4, 5: begin
        // BEQ or BNE, offset split around the register fields
        w = {b13[12], b13[10:5], rs2, rs1, (kind == 4) ? 3'b000 : 3'b001, b13[4:1],
             b13[11], OPC_BRANCH};
        e.op        = (kind == 4) ? OP_BEQ : OP_BNE;
        e.rs1       = rs1;
        e.rs2       = rs2;
        e.imm       = {{19{b13[12]}}, b13};
        e.ctrl_flow = 1'b1;
      end
      default: begin
        w           = {j21[20], j21[10:1], j21[11], j21[19:12], rd, OPC_JAL};
        e.op        = OP_JAL;
        e.rd        = rd;
        e.imm       = {{11{j21[20]}}, j21};
        e.ctrl_flow = 1'b1;
      end
    endcase
    e.orig = w;
  endtask

  // Random compressed word, expected as its 32-bit equivalent
  task automatic build_rvc(input int kind, output logic [31:0] w, output entry_t e);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [5:0]  i6;
    logic [11:0] off;
    logic [15:0] c;
    rd   = 5'($urandom);
    rs2  = 5'($urandom_range(31, 1));
    i6   = 6'($urandom);
    off  = {11'($urandom), 1'b0};
    e    = '0;
    e.rd = rd;
    case (kind)
      0, 1: begin
        // C.LI reads x0, C.ADDI reads rd
        c         = {(kind == 0) ? 3'b010 : 3'b000, i6[5], rd, i6[4:0], 2'b01};
        e.op      = OP_ADD;
        e.rs1     = (kind == 0) ? 5'd0 : rd;
        e.imm     = {{26{i6[5]}}, i6};
        e.use_imm = 1'b1;
      end
      2: begin
        // C.MV, rs2 never zero
        c     = {3'b100, 1'b0, rd, rs2, 2'b10};
        e.op  = OP_ADD;
        e.rs2 = rs2;
      end
      default: begin
        // C.J offset order 11|4|9:8|10|6|7|3:1|5
        c = {3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1],
             off[5], 2'b01};
        e.op        = OP_JAL;
        e.rd        = 5'd0;
        e.imm       = {{20{off[11]}}, off};
        e.ctrl_flow = 1'b1;
      end
    endcase
    e.compressed = 1'b1;
    e.orig       = {16'h0000, c};
    w            = {16'($urandom), c};
  endtask

  // One ADDI step of cm.mva01s
  function automatic entry_t macro_step(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [31:0] pc, input logic [15:0] c);
    entry_t e;
    e            = '0;
    e.op         = OP_ADD;
    e.rd         = rd;
    e.rs1        = rs1;
    e.use_imm    = 1'b1;
    e.compressed = 1'b1;
    e.pc         = pc;
    e.orig       = {16'h0000, c};
    return e;
  endfunction

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] w;
    logic [31:0] wb;
    logic [31:0] pc;
    logic [31:0] r;
    logic [15:0] c;
    logic [2:0]  r1s;
    logic [2:0]  r2s;
    entry_t      e;
    entry_t      eb;
    int          n;
    int          hold;
    int          c0;
    int          a0;
    int          delivered;
    int          dropped;

    void'($urandom(56));
    flush       = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = 32'h0;
    fetch_pc    = 32'h0;
    issue_ack   = 1'b0;
    checks      = 0;
    errors      = 0;

    // 1. Reset
    begin_test();
    n = 0;
    while (!rst_n) begin
      if (n == 10) begin
        abort("reset never released");
      end
      tick();
      n++;
    end
    tick();
    check_field("issue_valid_o", 32'(issue_valid), 32'd0);
    check_field("fetch_ready_o", 32'(fetch_ready), 32'd0);
    build_rv32(1, w, e);
    e.pc = 32'h0000_0100;
    present(w, e.pc);
    #1;
    check_field("fetch_ready_o", 32'(fetch_ready), 32'd1);
    take_fetch();
    check_entry(e);
    ack_entry();
    end_test("reset");

    // 2. Random 32-bit words
    begin_test();
    for (int k = 0; k < 40; k++) begin
      build_rv32($urandom_range(6, 0), w, e);
      e.pc = $urandom & 32'hffff_fffc;
      present(w, e.pc);
      take_fetch();
      check_entry(e);
      ack_entry();
    end
    end_test("decode32");

    // 3. Compressed expansion
    begin_test();
    for (int k = 0; k < 24; k++) begin
      build_rvc($urandom_range(3, 0), w, e);
      e.pc = $urandom & 32'hffff_fffe;
      present(w, e.pc);
      take_fetch();
      check_entry(e);
      ack_entry();
    end
    end_test("compressed");

    // 4. cm.mva01s as two ADDI steps
    begin_test();
    for (int k = 0; k < 6; k++) begin
      r1s = 3'($urandom);
      r2s = 3'($urandom);
      c   = {3'b101, 3'b011, r1s, 2'b11, r2s, 2'b10};
      pc  = $urandom & 32'hffff_fffe;
      present({16'($urandom), c}, pc);
      #1;
      check_field("fetch_ready_o", 32'(fetch_ready), 32'd0);
      tick();
      check_entry(macro_step(5'd10, S_MAP[r1s], pc, c));
      hold = $urandom_range(2, 0);
      for (int h = 0; h <= hold; h++) begin
        #1;
        check_field("fetch_ready_o", 32'(fetch_ready), 32'd0);
        check_entry(macro_step(5'd10, S_MAP[r1s], pc, c));
        tick();
      end
      // Ack of the first step lets the second load and frees fetch
      issue_ack = 1'b1;
      take_fetch();
      issue_ack = 1'b0;
      check_entry(macro_step(5'd11, S_MAP[r2s], pc, c));
      ack_entry();
      tick();
      check_field("issue_valid_o", 32'(issue_valid), 32'd0);
    end
    end_test("macro");

    // 5. Illegal words
    begin_test();
    for (int k = 0; k < 9; k++) begin
      r = $urandom;
      case (k)
        0: w = {r[31:7], 7'b0000011};
        1: w = {r[31:7], 7'b1110011};
        2: w = {r[31:15], 3'b010, r[11:7], OPC_OP_IMM};
        3: w = {7'b0000001, r[24:15], 3'b000, r[11:7], OPC_OP};
        4: w = {r[31:15], 3'b100, r[11:7], OPC_BRANCH};
        5: w = {r[31:16], 16'h0000};
        6: w = {r[31:16], 3'b010, r[12:2], 2'b00};
        // C.JR and a quadrant 2 word that is not the macro
        7: w = {r[31:16], 3'b100, 1'b0, r[11:7], 5'd0, 2'b10};
        default: w = {r[31:16], 3'b101, 3'b000, r[9:2], 2'b10};
      endcase
      pc = $urandom & 32'hffff_fffe;
      present(w, pc);
      take_fetch();
      check_illegal(w, pc);
      ack_entry();
    end
    end_test("illegal");

    // 6. Back-pressure and flush
    begin_test();
    c0        = consumed;
    a0        = acked;
    delivered = 0;
    dropped   = 0;
    for (int k = 0; k < 9; k++) begin
      build_rv32($urandom_range(6, 0), w, e);
      e.pc = $urandom & 32'hffff_fffc;
      present(w, e.pc);
      take_fetch();
      check_entry(e);
      build_rv32($urandom_range(6, 0), wb, eb);
      eb.pc = $urandom & 32'hffff_fffc;
      present(wb, eb.pc);
      hold = $urandom_range(4, 1);
      for (int h = 0; h < hold; h++) begin
        #1;
        check_field("fetch_ready_o", 32'(fetch_ready), 32'd0);
        check_entry(e);
        tick();
      end
      if (k % 3 == 2) begin
        // Flush drops the held entry and blocks the load
        flush = 1'b1;
        #1;
        check_field("fetch_ready_o", 32'(fetch_ready), 32'd0);
        tick();
        flush = 1'b0;
        check_field("issue_valid_o", 32'(issue_valid), 32'd0);
        dropped++;
        take_fetch();
      end else begin
        issue_ack = 1'b1;
        take_fetch();
        issue_ack = 1'b0;
        delivered++;
      end
      check_entry(eb);
      ack_entry();
      delivered++;
    end
    tick();
    check_field("issue_valid_o", 32'(issue_valid), 32'd0);
    // Every word taken from fetch is either acked by issue or dropped by a flush
    check_field("fetch handshakes", 32'(consumed - c0), 32'(delivered + dropped));
    check_field("issue acks", 32'(acked - a0), 32'(delivered));
    end_test("backpressure");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/id_pkg.sv
logic/rvc_expander.sv
logic/macro_sequencer.sv
logic/instr_decoder.sv
logic/id_stage.sv
verif/tb_clk_gen.sv
verif/tb_id_stage.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_id_stage
SRCS := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: run

$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module tb_id_stage

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
